// File: logic/dmc_pkg.sv
`default_nettype none

package dmc_pkg;

    // interval measurement widths
    localparam int TDC_W   = 5;
    localparam int JUDGE_W = TDC_W + 1;     // judge + margin, one bit of headroom

    // end of frame detection
    localparam int IDLE_TIMEOUT = 16;       // quiet cycles before receive done
    localparam int TIMER_W      = 5;        // must hold IDLE_TIMEOUT

    // one TDC strobe, pol is the line level during the interval
    typedef struct packed {
        logic             vld;
        logic             pol;
        logic [TDC_W-1:0] duration;
    } tdc_sample_t;

    // threshold setting of one channel
    typedef struct packed {
        logic [TDC_W-1:0] judge;
        logic [TDC_W-1:0] margin;
    } judge_cfg_t;

    typedef enum logic {
        EDGE_SHORT = 1'b0,
        EDGE_LONG  = 1'b1
    } edge_class_e;

    // classified interval handed to the symbol decoder
    typedef struct packed {
        logic        vld;
        logic        pol;
        edge_class_e cls;
    } edge_item_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,    // waiting for the first (truncated) interval
        ST_READY = 2'd1,    // at a symbol boundary
        ST_HALF  = 2'd2     // one short interval seen
    } dec_state_e;

endpackage

`default_nettype wire

// File: logic/tdc_sample_select.sv
`default_nettype none
`timescale 1ns/100ps

module tdc_sample_select import dmc_pkg::*; (
    input  wire         clk_or_data,
    input  wire         reset_n,
    input  tdc_sample_t sample_a_i,
    input  tdc_sample_t sample_b_i,
    input  judge_cfg_t  cfg_a_i,
    input  judge_cfg_t  cfg_b_i,
    input  wire         arx_en_i,
    input  wire         brx_en_i,
    output tdc_sample_t sample_o,
    output judge_cfg_t  cfg_o
);

    tdc_sample_t pick_sample;               // channel A wins when both enabled
    judge_cfg_t  pick_cfg;
    logic        pick_vld;

    logic             vld_q;
    logic             pol_q;
    logic [TDC_W-1:0] dur_q;
    judge_cfg_t       cfg_q;

    always_comb begin
        if (arx_en_i) begin
            pick_sample = sample_a_i;
            pick_cfg    = cfg_a_i;
        end else begin
            pick_sample = sample_b_i;
            pick_cfg    = cfg_b_i;
        end
    end

    // a strobe on a disabled channel is dropped here
    assign pick_vld = (arx_en_i || brx_en_i) && pick_sample.vld;

    always_ff @(posedge clk_or_data or negedge reset_n) begin
        if (!reset_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= pick_vld;
        end
    end

    // payload follows the selected channel every cycle
    always_ff @(posedge clk_or_data) begin
        pol_q <= pick_sample.pol;
        dur_q <= pick_sample.duration;
        cfg_q <= pick_cfg;                  // cfg travels with its sample
    end

    assign sample_o = '{
        vld:      vld_q,
        pol:      pol_q,
        duration: dur_q
    };

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: logic/edge_classifier.sv
`default_nettype none
`timescale 1ns/100ps

module edge_classifier import dmc_pkg::*; (
    input  wire         clk_or_data,
    input  wire         reset_n,
    input  tdc_sample_t sample_i,
    input  judge_cfg_t  cfg_i,
    output edge_item_t  edge_o
);

    logic [JUDGE_W-1:0] limit;              // judge + margin, no overflow
    logic [JUDGE_W-1:0] duration_ext;
    edge_class_e        cls_d;

    logic        vld_q;
    logic        pol_q;
    edge_class_e cls_q;

    assign limit        = {1'b0, cfg_i.judge} + {1'b0, cfg_i.margin};
    assign duration_ext = {1'b0, sample_i.duration};

    // the boundary value itself still counts as short
    assign cls_d = (duration_ext > limit) ? EDGE_LONG : EDGE_SHORT;

    always_ff @(posedge clk_or_data or negedge reset_n) begin
        if (!reset_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= sample_i.vld;
        end
    end

    always_ff @(posedge clk_or_data) begin
        pol_q <= sample_i.pol;
        cls_q <= cls_d;
    end

    assign edge_o = '{
        vld: vld_q,
        pol: pol_q,
        cls: cls_q
    };

endmodule

`default_nettype wire

// File: logic/dmc_symbol_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module dmc_symbol_decoder import dmc_pkg::*; (
    input  wire        clk_or_data,
    input  wire        reset_n,
    input  edge_item_t edge_i,
    output logic       bit_o,
    output logic       bit_vld_o,
    output logic       frame_error_o,
    output logic       receive_done_o,
    output logic       bit_cnt_begin_o
);

    dec_state_e         state;
    dec_state_e         eff_state;          // state as seen this cycle
    logic [TIMER_W-1:0] quiet_cnt;          // cycles since the last edge
    logic               timeout_hit;
    logic               is_long;

    // the done cycle already belongs to the next frame, so an edge arriving
    // right then is taken as a fresh first interval
    assign eff_state = receive_done_o ? ST_IDLE : state;

    assign is_long = (edge_i.cls == EDGE_LONG);

    // edge strobe in cycle E sets the count to 1, so done shows at E+IDLE_TIMEOUT
    assign timeout_hit = (quiet_cnt == TIMER_W'(IDLE_TIMEOUT - 1));

    always_ff @(posedge clk_or_data or negedge reset_n) begin
        if (!reset_n) begin
            state           <= ST_IDLE;
            quiet_cnt       <= '0;
            bit_vld_o       <= 1'b0;
            frame_error_o   <= 1'b0;
            receive_done_o  <= 1'b0;
            bit_cnt_begin_o <= 1'b0;
        end else begin
            bit_vld_o      <= 1'b0;
            frame_error_o  <= 1'b0;
            receive_done_o <= 1'b0;
            state          <= eff_state;

            if (edge_i.vld) begin
                quiet_cnt <= TIMER_W'(1);
                case (eff_state)
                    ST_IDLE: begin
                        // first interval may be cut short, only its level is used
                        bit_cnt_begin_o <= ~edge_i.pol;
                        state           <= ST_READY;
                    end
                    ST_READY: begin
                        if (is_long) begin
                            bit_vld_o <= 1'b1;      // long interval is a 1
                        end else begin
                            state <= ST_HALF;
                        end
                    end
                    ST_HALF: begin
                        state <= ST_READY;
                        if (is_long) begin
                            frame_error_o <= 1'b1;  // short then long, no symbol
                        end else begin
                            bit_vld_o <= 1'b1;      // two shorts make a 0
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end else if (eff_state != ST_IDLE) begin
                quiet_cnt <= quiet_cnt + 1'b1;
                if (timeout_hit) begin
                    // pending half symbol is simply dropped
                    receive_done_o <= 1'b1;
                end
            end
        end
    end

    // bit value only matters while bit_vld_o is high
    always_ff @(posedge clk_or_data) begin
        if (edge_i.vld) begin
            bit_o <= is_long;
        end
    end

endmodule

`default_nettype wire

// File: logic/dmc_decode_top.sv
`default_nettype none
`timescale 1ns/100ps

module dmc_decode_top import dmc_pkg::*; (
    input  wire         clk_or_data,
    input  wire         reset_n,
    input  tdc_sample_t sample_a_i,
    input  tdc_sample_t sample_b_i,
    input  judge_cfg_t  cfg_a_i,
    input  judge_cfg_t  cfg_b_i,
    input  wire         arx_en_i,
    input  wire         brx_en_i,
    output logic        bit_o,
    output logic        bit_vld_o,
    output logic        frame_error_o,
    output logic        receive_done_o,
    output logic        bit_cnt_begin_o
);

    tdc_sample_t sel_sample;                // stage 1 to stage 2
    judge_cfg_t  sel_cfg;
    edge_item_t  edge_item;                 // stage 2 to decoder

    // channel pick, A before B
    tdc_sample_select u_sample_select (
        .clk_or_data (clk_or_data),
        .reset_n     (reset_n),
        .sample_a_i  (sample_a_i),
        .sample_b_i  (sample_b_i),
        .cfg_a_i     (cfg_a_i),
        .cfg_b_i     (cfg_b_i),
        .arx_en_i    (arx_en_i),
        .brx_en_i    (brx_en_i),
        .sample_o    (sel_sample),
        .cfg_o       (sel_cfg)
    );

    // short or long against judge + margin
    edge_classifier u_edge_classifier (
        .clk_or_data (clk_or_data),
        .reset_n     (reset_n),
        .sample_i    (sel_sample),
        .cfg_i       (sel_cfg),
        .edge_o      (edge_item)
    );

    // intervals to bits, framing and end of frame
    dmc_symbol_decoder u_symbol_decoder (
        .clk_or_data     (clk_or_data),
        .reset_n         (reset_n),
        .edge_i          (edge_item),
        .bit_o           (bit_o),
        .bit_vld_o       (bit_vld_o),
        .frame_error_o   (frame_error_o),
        .receive_done_o  (receive_done_o),
        .bit_cnt_begin_o (bit_cnt_begin_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;      // 8 ns period
        end
    end

    // reset held over the first two rising edges
    initial begin
        reset_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/dmc_decode_props.sv
`default_nettype none
`timescale 1ns/100ps

module dmc_decode_props import dmc_pkg::*; (
    input  wire        clk_i,
    input  wire        reset_n_i,
    input  dec_state_e state_i,
    input  wire        bit_vld_i,
    input  wire        frame_error_i,
    input  wire        receive_done_i
);

    // an interval pair either decodes or fails
    bit_or_error: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        !(bit_vld_i && frame_error_i)
    ) else $error("bit_vld and frame_error high in the same cycle");

    // done is raised while the frame is still open
    done_not_idle: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        receive_done_i |-> (state_i != ST_IDLE)
    ) else $error("receive_done high while decoder is idle");

    legal_state: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        state_i inside {ST_IDLE, ST_READY, ST_HALF}
    ) else $error("decoder state left the legal encodings");

endmodule

`default_nettype wire

// File: verification/tb_dmc_decode.sv
`default_nettype none
`timescale 1ns/100ps

module tb_dmc_decode import dmc_pkg::*; ();

    logic        clk_or_data;
    logic        reset_n;
    tdc_sample_t sample_a_i;
    tdc_sample_t sample_b_i;
    judge_cfg_t  cfg_a_i;
    judge_cfg_t  cfg_b_i;
    logic        arx_en_i;
    logic        brx_en_i;
    logic        bit_o;
    logic        bit_vld_o;
    logic        frame_error_o;
    logic        receive_done_o;
    logic        bit_cnt_begin_o;

    logic [31:0] lfsr_state = 32'h772e72c1;
    int          cyc = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;
    int          failed_tests = 0;
    int          test_err_base = 0;
    bit          hung = 1'b0;

    int          active_chan = 0;       // 0 drives A, 1 drives B
    bit          noise_on = 1'b0;       // junk strobes on the other channel
    bit          expect_on = 1'b1;      // model follows the driven intervals
    int          cur_limit = 0;         // judge + margin of the winning channel

    dec_state_e  m_state = ST_IDLE;
    logic        m_flag = 1'b0;
    int          m_last = 0;            // cycle of the last driven interval

    logic exp_bit_val[$];
    int   exp_bit_cyc[$];
    int   exp_err_cyc[$];
    int   exp_done_cyc[$];
    logic exp_done_flag[$];
    logic obs_bit_val[$];
    int   obs_bit_cyc[$];
    int   obs_err_cyc[$];
    int   obs_done_cyc[$];
    logic obs_done_flag[$];

    tb_clock_gen u_clock_gen (
        .clk_o     (clk_or_data),
        .reset_n_o (reset_n)
    );

    dmc_decode_top dut (
        .clk_or_data     (clk_or_data),
        .reset_n         (reset_n),
        .sample_a_i      (sample_a_i),
        .sample_b_i      (sample_b_i),
        .cfg_a_i         (cfg_a_i),
        .cfg_b_i         (cfg_b_i),
        .arx_en_i        (arx_en_i),
        .brx_en_i        (brx_en_i),
        .bit_o           (bit_o),
        .bit_vld_o       (bit_vld_o),
        .frame_error_o   (frame_error_o),
        .receive_done_o  (receive_done_o),
        .bit_cnt_begin_o (bit_cnt_begin_o)
    );

    bind dmc_symbol_decoder dmc_decode_props u_props (
        .clk_i          (clk_or_data),
        .reset_n_i      (reset_n),
        .state_i        (state),
        .bit_vld_i      (bit_vld_o),
        .frame_error_i  (frame_error_o),
        .receive_done_i (receive_done_o)
    );

    always @(posedge clk_or_data) cyc <= cyc + 1;

    // outputs are sampled mid cycle, away from the clock edge
    always @(negedge clk_or_data) begin
        if (bit_vld_o === 1'b1) begin
            obs_bit_val.push_back(bit_o);
            obs_bit_cyc.push_back(cyc);
        end
        if (frame_error_o === 1'b1) begin
            obs_err_cyc.push_back(cyc);
        end
        if (receive_done_o === 1'b1) begin
            obs_done_cyc.push_back(cyc);
            obs_done_flag.push_back(bit_cnt_begin_o);
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int next_rand(int nbits);
        int r;
        r = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    function automatic int rand_range(int lo, int hi);
        return lo + (next_rand(8) % (hi - lo + 1));
    endfunction

    function automatic int short_dur();
        if (next_rand(2) == 0) begin
            return cur_limit;               // right on the boundary
        end
        return rand_range(1, cur_limit);
    endfunction

    function automatic int long_dur();
        if (next_rand(2) == 0) begin
            return cur_limit + 1;
        end
        return rand_range(cur_limit + 1, 31);
    endfunction

    task automatic check_bit(logic exp, logic got, string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL @%0t %s: expected %b, got %b", $time, what, exp, got);
        end
    endtask

    task automatic check_flag(logic exp, logic got, string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL @%0t %s: expected %b, got %b", $time, what, exp, got);
        end
    endtask

    task automatic check_count(int exp, int got, string what);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("FAIL @%0t %s: expected %0d, got %0d", $time, what, exp, got);
        end
    endtask

    // symbol rules, results land 3 cycles after the completing strobe
    task automatic model_interval(logic pol, bit is_long, int stamp);
        m_last = stamp;
        if (m_state == ST_IDLE) begin
            m_flag  = ~pol;                 // level of the discarded interval
            m_state = ST_READY;
        end else if (m_state == ST_READY) begin
            if (is_long) begin
                exp_bit_val.push_back(1'b1);
                exp_bit_cyc.push_back(stamp + 3);
            end else begin
                m_state = ST_HALF;
            end
        end else begin
            m_state = ST_READY;
            if (is_long) begin
                exp_err_cyc.push_back(stamp + 3);
            end else begin
                exp_bit_val.push_back(1'b0);
                exp_bit_cyc.push_back(stamp + 3);
            end
        end
    endtask

    task automatic model_frame_end();
        if (m_state != ST_IDLE) begin
            exp_done_cyc.push_back(m_last + 2 + IDLE_TIMEOUT);
            exp_done_flag.push_back(m_flag);
        end
        m_state = ST_IDLE;
    endtask

    task automatic send_interval(logic pol, int dur);
        tdc_sample_t s;
        tdc_sample_t junk;
        int          stamp;
        int          gap;
        s     = '{vld: 1'b1, pol: pol, duration: TDC_W'(dur)};
        junk  = '{vld: 1'b1, pol: ~pol, duration: TDC_W'(next_rand(TDC_W))};
        stamp = cyc;
        if (active_chan == 0) begin
            sample_a_i = s;
            if (noise_on) sample_b_i = junk;
        end else begin
            sample_b_i = s;
            if (noise_on) sample_a_i = junk;
        end
        @(posedge clk_or_data);
        #1;
        sample_a_i = '0;
        sample_b_i = '0;
        if (expect_on) model_interval(pol, dur > cur_limit, stamp);
        gap = next_rand(2);
        repeat (gap) begin
            @(posedge clk_or_data);
            #1;
        end
    endtask

    task automatic send_frame(logic first_pol, int nbits, int err_at);
        logic pol;
        pol = first_pol;
        send_interval(pol, rand_range(1, 31));      // truncated lead-in
        for (int i = 0; i < nbits; i++) begin
            if (i == err_at) begin
                pol = ~pol;
                send_interval(pol, short_dur());
                pol = ~pol;
                send_interval(pol, long_dur());     // broken half symbol
            end
            pol = ~pol;
            if (next_rand(1) != 0) begin
                send_interval(pol, long_dur());
            end else begin
                send_interval(pol, short_dur());
                pol = ~pol;
                send_interval(pol, short_dur());
            end
        end
        repeat (IDLE_TIMEOUT + 8) begin
            @(posedge clk_or_data);
            #1;
        end
        if (expect_on) model_frame_end();
    endtask

    task automatic wait_dones();
        int guard;
        guard = 0;
        while (obs_done_cyc.size() < exp_done_cyc.size() && guard < 100) begin
            @(posedge clk_or_data);
            #1;
            guard++;
        end
        if (obs_done_cyc.size() < exp_done_cyc.size()) begin
            $display("timeout: only %0d of %0d receive_done pulses arrived",
                     obs_done_cyc.size(), exp_done_cyc.size());
            hung = 1'b1;
        end
    endtask

    task automatic compare_results();
        int n;
        check_count(exp_bit_val.size(), obs_bit_val.size(), "decoded bit count");
        n = (exp_bit_val.size() < obs_bit_val.size()) ? exp_bit_val.size() : obs_bit_val.size();
        for (int i = 0; i < n; i++) begin
            check_bit(exp_bit_val[i], obs_bit_val[i], $sformatf("bit %0d value", i));
            check_count(exp_bit_cyc[i], obs_bit_cyc[i], $sformatf("bit %0d cycle", i));
        end
        check_count(exp_err_cyc.size(), obs_err_cyc.size(), "frame error count");
        n = (exp_err_cyc.size() < obs_err_cyc.size()) ? exp_err_cyc.size() : obs_err_cyc.size();
        for (int i = 0; i < n; i++) begin
            check_count(exp_err_cyc[i], obs_err_cyc[i], $sformatf("error %0d cycle", i));
        end
        check_count(exp_done_cyc.size(), obs_done_cyc.size(), "receive done count");
        n = (exp_done_cyc.size() < obs_done_cyc.size()) ? exp_done_cyc.size() : obs_done_cyc.size();
        for (int i = 0; i < n; i++) begin
            check_count(exp_done_cyc[i], obs_done_cyc[i], $sformatf("done %0d cycle", i));
            check_flag(exp_done_flag[i], obs_done_flag[i], $sformatf("begin flag %0d", i));
        end
        exp_bit_val.delete();
        exp_bit_cyc.delete();
        exp_err_cyc.delete();
        exp_done_cyc.delete();
        exp_done_flag.delete();
        obs_bit_val.delete();
        obs_bit_cyc.delete();
        obs_err_cyc.delete();
        obs_done_cyc.delete();
        obs_done_flag.delete();
    endtask

    task automatic finish_test(string name);
        test_cnt++;
        if (err_cnt == test_err_base) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    task automatic use_channels(logic a_en, logic b_en, int chan, bit noise, bit follow);
        arx_en_i    = a_en;
        brx_en_i    = b_en;
        active_chan = chan;
        noise_on    = noise;
        expect_on   = follow;
        if (chan == 0) begin
            cur_limit = int'(cfg_a_i.judge) + int'(cfg_a_i.margin);
        end else begin
            cur_limit = int'(cfg_b_i.judge) + int'(cfg_b_i.margin);
        end
        @(posedge clk_or_data);
        #1;
    endtask

    task automatic run_reset_test();
        int guard;
        guard = 0;
        while (reset_n !== 1'b1 && guard < 20) begin
            @(negedge clk_or_data);
            check_flag(1'b0, bit_vld_o, "bit_vld_o in reset");
            check_flag(1'b0, frame_error_o, "frame_error_o in reset");
            check_flag(1'b0, receive_done_o, "receive_done_o in reset");
            guard++;
        end
        if (reset_n !== 1'b1) begin
            $display("reset was never released");
            hung = 1'b1;
        end else begin
            repeat (4) begin
                @(negedge clk_or_data);
                check_flag(1'b0, bit_vld_o, "bit_vld_o after reset");
                check_flag(1'b0, frame_error_o, "frame_error_o after reset");
                check_flag(1'b0, receive_done_o, "receive_done_o after reset");
                check_flag(1'b0, bit_cnt_begin_o, "bit_cnt_begin_o after reset");
            end
            check_count(int'(ST_IDLE), int'(dut.u_symbol_decoder.state), "state after reset");
        end
        @(posedge clk_or_data);
        #1;
        compare_results();
        finish_test("reset");
    endtask

    task automatic run_frames(string name, int frames, bit with_error, bit fixed_pol);
        logic first_pol;
        int   err_at;
        for (int f = 0; f < frames; f++) begin
            first_pol = fixed_pol ? f[0] : (next_rand(1) != 0);
            err_at    = with_error ? rand_range(0, 3) : -1;
            send_frame(first_pol, rand_range(4, 10), err_at);
        end
        wait_dones();
        compare_results();
        finish_test(name);
    endtask

    initial begin
        sample_a_i = '0;
        sample_b_i = '0;
        cfg_a_i    = '{judge: 5'd9, margin: 5'd4};     // limit 13
        cfg_b_i    = '{judge: 5'd5, margin: 5'd2};     // limit 7
        arx_en_i   = 1'b0;
        brx_en_i   = 1'b0;

        run_reset_test();
        use_channels(1'b1, 1'b0, 0, 1'b0, 1'b1);
        if (!hung) run_frames("channel A decoding", 6, 1'b0, 1'b0);
        use_channels(1'b0, 1'b1, 1, 1'b0, 1'b1);
        if (!hung) run_frames("channel B decoding", 4, 1'b0, 1'b0);
        use_channels(1'b1, 1'b1, 0, 1'b1, 1'b1);
        if (!hung) run_frames("both enabled, A wins", 4, 1'b0, 1'b0);
        use_channels(1'b0, 1'b0, 0, 1'b1, 1'b0);
        if (!hung) run_frames("no channel enabled", 3, 1'b0, 1'b0);
        use_channels(1'b1, 1'b0, 0, 1'b0, 1'b1);
        if (!hung) run_frames("first interval and begin flag", 4, 1'b0, 1'b1);
        if (!hung) run_frames("framing error", 5, 1'b1, 1'b0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, failed_tests, check_cnt, err_cnt);
        if (err_cnt == 0 && !hung) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dmc_decode_top.f
logic/dmc_pkg.sv
logic/tdc_sample_select.sv
logic/edge_classifier.sv
logic/dmc_symbol_decoder.sv
logic/dmc_decode_top.sv
verification/tb_clock_gen.sv
verification/dmc_decode_props.sv
verification/tb_dmc_decode.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dmc_decode -f dmc_decode_top.f \
    --Mdir obj_dir -o tb_dmc_decode
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dmc_decode > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0
